// File: hdl/capture_pkg.sv
package capture_pkg;

    ////////////////////
    // Data widths
    ////////////////////

    typedef logic [15:0] sample_t;      // One GTP receive sample
    typedef logic [31:0] word_t;        // Memory and bus word, two samples
    typedef logic [3:0]  sel_t;         // Wishbone byte lanes, bit 0 is [7:0]
    typedef logic [8:0]  bus_addr_t;    // Word address on the bus

    // The bus map always spans 512 words
    // Smaller buffers alias into it through the low address bits

    ////////////////////
    // Packer FSM
    ////////////////////

    typedef enum logic [1:0] {
        idle,       // After reset, waiting for the first run edge
        capture,    // Pairing samples into words
        done        // Buffer full, samples dropped until re-arm
    } packer_state_t;

    ////////////////////
    // Sizes
    ////////////////////

    // Capture words per run, twice as many samples
    localparam int DEFAULT_DEPTH = 256;

endpackage

// File: hdl/capture_stream_if.sv
`timescale 1ns/1ps

interface capture_stream_if;
    import capture_pkg::*;

    logic  valid;   // Packed word waiting on data
    logic  ready;   // Buffer write port free this cycle
    word_t data;    // {second sample, first sample}
    logic  last;    // Word closes the capture

    // A word moves on an edge with valid and ready both high
    // data and last stay put from valid until the transfer
    // last high with valid low is the arm marker, the next word goes to address 0

    modport src (
        output valid,
        output data,
        output last,
        input  ready
    );

    modport dst (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

// File: hdl/capture_mem_if.sv
`timescale 1ns/1ps

interface capture_mem_if;
    import capture_pkg::*;

    bus_addr_t addr;    // Word address from the bus
    logic      we;      // Write strobe, one cycle per access
    sel_t      sel;     // Byte lanes to write
    word_t     wdata;   // Write data
    word_t     rdata;   // Registered read data, valid with ack
    logic      busy;    // Access seen this cycle, loads rdata

    // we never rises without busy
    // The memory side gives the write port to we and holds the stream back

    modport bus (
        output addr,
        output we,
        output sel,
        output wdata,
        output busy,
        input  rdata
    );

    modport mem (
        input  addr,
        input  we,
        input  sel,
        input  wdata,
        input  busy,
        output rdata
    );

endinterface

// File: hdl/sample_packer.sv
`timescale 1ns/1ps

module sample_packer #(
    parameter int DEPTH = capture_pkg::DEFAULT_DEPTH
) (
    input  logic                 gtp_clk,
    input  logic                 reset,
    input  logic                 cntrl_run,
    input  capture_pkg::sample_t gtp_dat,
    input  logic                 gtp_vld,
    capture_stream_if.src        out_stream
);
    import capture_pkg::*;

    localparam int CNT_W = $clog2(DEPTH);   // Word counter width

    logic             run_meta;     // First synchronizer flop
    logic             run_sync;     // Second synchronizer flop
    logic             run_prev;     // History for the edge detect
    logic             arm;          // Accepted rising edge of cntrl_run
    packer_state_t    state;
    sample_t          half;         // Even sample waiting for its partner
    logic             have_half;    // half holds a sample
    logic [CNT_W-1:0] word_cnt;     // Words emitted in this capture
    logic             last_q;       // Emitted word is the final one
    logic             take;         // Sample accepted this cycle
    logic             word_end;     // Accepted sample completes a pair

    ////////////////////
    // Run edge
    ////////////////////

    // cntrl_run is written by software, so it is synchronized first
    always_ff @(posedge gtp_clk) begin
        if (reset) begin
            run_meta <= 1'b0;
            run_sync <= 1'b0;
            run_prev <= 1'b0;
        end else begin
            run_meta <= cntrl_run;
            run_sync <= run_meta;
            run_prev <= run_sync;
        end
    end

    // Edges inside a capture are ignored
    // A word still waiting for ready also blocks arming for that cycle
    assign arm = run_sync && !run_prev && (state != capture) && !out_stream.valid;

    ////////////////////
    // Pairing FSM
    ////////////////////

    assign take     = (state == capture) && gtp_vld;
    assign word_end = take && have_half;

    always_ff @(posedge gtp_clk) begin
        if (reset) begin
            state            <= idle;
            have_half        <= 1'b0;
            word_cnt         <= '0;
            last_q           <= 1'b0;
            out_stream.valid <= 1'b0;
        end else begin
            if (out_stream.valid && out_stream.ready) begin
                out_stream.valid <= 1'b0;       // Buffer took the word
            end
            if (arm) begin
                state     <= capture;
                have_half <= 1'b0;              // Drop any stale half-word
                word_cnt  <= '0;
                last_q    <= 1'b0;
            end else if (take) begin
                have_half <= !have_half;
                if (word_end) begin
                    out_stream.valid <= 1'b1;   // Set wins over the clear above
                    last_q           <= (word_cnt == CNT_W'(DEPTH - 1));
                    word_cnt         <= word_cnt + 1'b1;
                    if (word_cnt == CNT_W'(DEPTH - 1)) begin
                        state <= done;          // Later samples are ignored
                    end
                end
            end
        end
    end

    // Payload registers
    always_ff @(posedge gtp_clk) begin
        if (word_end) begin
            out_stream.data <= {gtp_dat, half};     // Low sample first
        end else if (take) begin
            half <= gtp_dat;
        end
    end

    // Arm rides on last while valid is low
    // The final word flags last only while it waits for the transfer
    assign out_stream.last = (last_q && out_stream.valid) || arm;

endmodule

// File: hdl/capture_ram.sv
`timescale 1ns/1ps

module capture_ram #(
    parameter int DEPTH = capture_pkg::DEFAULT_DEPTH
) (
    input  logic          gtp_clk,
    input  logic          reset,
    capture_stream_if.dst in_stream,
    capture_mem_if.mem    bus,
    output logic          cntrl_ready
);
    import capture_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);   // Word index width
    localparam int LANES = $bits(sel_t);    // Byte lanes per word

    word_t            mem [DEPTH];  // Capture storage
    logic [PTR_W-1:0] wr_ptr;       // Next stream word
    logic [PTR_W-1:0] bus_idx;      // Bus address folded onto the buffer
    logic             stream_wr;    // Stream word written this cycle
    logic             arm_seen;     // Packer started a new capture
    word_t            bus_old;      // Current word at the bus address
    word_t            bus_merged;   // Same word after the bus write
    logic             wr_en;
    logic [PTR_W-1:0] wr_addr;
    word_t            wr_data;
    sel_t             wr_be;        // Per-lane write enable

    ////////////////////
    // Write port
    ////////////////////

    assign in_stream.ready = !bus.we;       // Bus write owns the port
    assign stream_wr       = in_stream.valid && in_stream.ready;
    assign arm_seen        = in_stream.last && !in_stream.valid;
    assign bus_idx         = bus.addr[PTR_W-1:0];

    // One port shared by both writers
    assign wr_en   = bus.we || stream_wr;
    assign wr_addr = bus.we ? bus_idx : wr_ptr;
    assign wr_data = bus.we ? bus.wdata : in_stream.data;
    assign wr_be   = bus.we ? bus.sel : '1;  // Stream words write all lanes

    always_ff @(posedge gtp_clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (wr_en && wr_be[i]) begin
                mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
            end
        end
    end

    ////////////////////
    // Read port
    ////////////////////

    assign bus_old = mem[bus_idx];

    // A write access returns the merged word
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            bus_merged[8*i +: 8] = bus.sel[i] ? bus.wdata[8*i +: 8] : bus_old[8*i +: 8];
        end
    end

    always_ff @(posedge gtp_clk) begin
        if (bus.busy) begin
            bus.rdata <= bus.we ? bus_merged : bus_old;  // Held between accesses
        end
    end

    // Pointer and full flag
    always_ff @(posedge gtp_clk) begin
        if (reset) begin
            wr_ptr      <= '0;
            cntrl_ready <= 1'b0;
        end else if (arm_seen) begin
            wr_ptr      <= '0;          // New capture starts at word 0
            cntrl_ready <= 1'b0;
        end else if (stream_wr) begin
            wr_ptr <= wr_ptr + 1'b1;    // Wraps at DEPTH
            if (in_stream.last) begin
                cntrl_ready <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/wb_readout.sv
`timescale 1ns/1ps

module wb_readout (
    input  logic                   gtp_clk,
    input  logic                   reset,
    input  capture_pkg::bus_addr_t wb_adr,
    input  capture_pkg::word_t     wb_dat_i,
    input  capture_pkg::sel_t      wb_sel,
    input  logic                   wb_we,
    input  logic                   wb_stb,
    input  logic                   wb_cyc,
    output logic                   wb_ack,
    output capture_pkg::word_t     wb_dat_o,
    capture_mem_if.bus             mem
);

    logic req;  // New access seen this cycle

    ////////////////////
    // Handshake
    ////////////////////

    // Ack drops for one cycle after each access,
    // so a held stb starts a fresh access every other cycle
    assign req = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge gtp_clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    ////////////////////
    // Memory side
    ////////////////////

    assign mem.busy  = req;             // Loads rdata for the ack cycle
    assign mem.addr  = wb_adr;
    assign mem.we    = req && wb_we;    // Exactly one write per access
    assign mem.sel   = wb_sel;
    assign mem.wdata = wb_dat_i;

    // Data bus is quiet outside ack
    assign wb_dat_o = wb_ack ? mem.rdata : '0;

endmodule

// File: hdl/capture_top.sv
`timescale 1ns/1ps

module capture_top #(
    parameter int DEPTH = capture_pkg::DEFAULT_DEPTH   // Power of two, 512 at most
) (
    input  logic                   gtp_clk,
    input  logic                   reset,

    // Wishbone classic slave
    input  capture_pkg::bus_addr_t wb_adr,
    input  capture_pkg::word_t     wb_dat_i,
    input  capture_pkg::sel_t      wb_sel,
    input  logic                   wb_we,
    input  logic                   wb_stb,
    input  logic                   wb_cyc,
    output logic                   wb_ack,
    output capture_pkg::word_t     wb_dat_o,

    // Receive stream and control
    input  capture_pkg::sample_t   gtp_dat,
    input  logic                   gtp_vld,
    input  logic                   cntrl_run,
    output logic                   cntrl_ready
);

    capture_stream_if stream_if ();  // Packer to buffer
    capture_mem_if    mem_if ();     // Bus to buffer

    ////////////////////
    // Blocks
    ////////////////////

    sample_packer #(
        .DEPTH (DEPTH)
    ) i_packer (
        .gtp_clk    (gtp_clk),
        .reset      (reset),
        .cntrl_run  (cntrl_run),
        .gtp_dat    (gtp_dat),
        .gtp_vld    (gtp_vld),
        .out_stream (stream_if.src)
    );

    capture_ram #(
        .DEPTH (DEPTH)
    ) i_ram (
        .gtp_clk     (gtp_clk),
        .reset       (reset),
        .in_stream   (stream_if.dst),
        .bus         (mem_if.mem),
        .cntrl_ready (cntrl_ready)
    );

    wb_readout i_wb (
        .gtp_clk  (gtp_clk),
        .reset    (reset),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_sel   (wb_sel),
        .wb_we    (wb_we),
        .wb_stb   (wb_stb),
        .wb_cyc   (wb_cyc),
        .wb_ack   (wb_ack),
        .wb_dat_o (wb_dat_o),
        .mem      (mem_if.bus)
    );

endmodule

// File: bench/capture_tb.sv
`timescale 1ns/1ps

module capture_tb;
    import capture_pkg::*;

    localparam int DEPTH = 256;
    localparam int EXTRA = 8;           // Samples sent after the buffer is full

    logic        gtp_clk = 1'b0;
    logic        reset;
    bus_addr_t   wb_adr;
    word_t       wb_dat_i;
    sel_t        wb_sel;
    logic        wb_we;
    logic        wb_stb;
    logic        wb_cyc;
    logic        wb_ack;
    word_t       wb_dat_o;
    sample_t     gtp_dat;
    logic        gtp_vld;
    logic        cntrl_run;
    logic        cntrl_ready;

    word_t       model [DEPTH];         // Expected memory contents
    logic [31:0] seed = 32'h6235_c923;  // LCG state
    int          taken;                 // Valid samples sent in this run
    int          cycles = 0;
    int          limit = 200;           // Grows with every capture and access
    int          word_errs = 0;
    int          flag_errs = 0;
    int          other_errs = 0;

    capture_top #(
        .DEPTH (DEPTH)
    ) i_dut (
        .gtp_clk     (gtp_clk),
        .reset       (reset),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_sel      (wb_sel),
        .wb_we       (wb_we),
        .wb_stb      (wb_stb),
        .wb_cyc      (wb_cyc),
        .wb_ack      (wb_ack),
        .wb_dat_o    (wb_dat_o),
        .gtp_dat     (gtp_dat),
        .gtp_vld     (gtp_vld),
        .cntrl_run   (cntrl_run),
        .cntrl_ready (cntrl_ready)
    );

    always #4 gtp_clk = ~gtp_clk;       // 8 ns period

    // Watchdog
    always @(posedge gtp_clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Lanes with sel set take the new byte
    function automatic word_t merge_lanes(input word_t old, input word_t data, input sel_t sel);
        word_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            word_errs++;
            $display("Error %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errs++;
            $display("Error %s: expected cntrl_ready %b, actual %b", name, exp, act);
        end
    endtask

    // One Wishbone classic access with data taken while ack is high
    task automatic bus_access(input bus_addr_t addr, input logic we, input sel_t sel,
                              input word_t data, output word_t rd);
        int n;
        limit += 4;
        @(posedge gtp_clk);
        wb_adr   <= addr;
        wb_we    <= we;
        wb_sel   <= sel;
        wb_dat_i <= data;
        wb_stb   <= 1'b1;
        wb_cyc   <= 1'b1;
        n = 0;
        do begin
            @(negedge gtp_clk);
            n++;
        end while (!wb_ack && n < 8);
        if (!wb_ack) begin
            other_errs++;
            $display("Bus access to address %03h got no ack", addr);
        end
        rd = wb_dat_o;
        @(posedge gtp_clk);
        wb_stb <= 1'b0;             // Ack falls on this edge
        wb_cyc <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    ////////////////////
    // Capture
    ////////////////////

    task automatic drive_samples(input string name, input int gap);
        int c;
        c = 0;
        while (taken < 2 * DEPTH + EXTRA) begin
            if (taken == 2 * DEPTH) begin
                @(negedge gtp_clk);
                check_flag({name, " before last word"}, 1'b0, cntrl_ready);
            end
            @(posedge gtp_clk);
            seed = lcg_next(seed);
            c++;
            gtp_dat <= seed[31:16];
            if (gap != 0 && c % gap == 0) begin
                gtp_vld <= 1'b0;    // Gap cycle with noise on the data
            end else begin
                gtp_vld <= 1'b1;
                if (taken < 2 * DEPTH) begin
                    if (taken % 2 == 0) model[taken / 2][15:0] = seed[31:16];
                    else model[taken / 2][31:16] = seed[31:16];  // Second sample on top
                end
                taken++;            // Extras past 2*DEPTH must be dropped
            end
        end
        @(posedge gtp_clk);
        gtp_vld <= 1'b0;
    endtask

    // Partial writes to words the stream has already stored
    task automatic bus_during_capture(input string name, input int nwr);
        int    idx;
        sel_t  sel;
        word_t data;
        word_t rd;
        for (int i = 0; i < nwr; i++) begin
            do begin
                @(negedge gtp_clk);
            end while (taken < (i + 1) * 2 * DEPTH / (nwr + 1));
            idx        = taken / 2 - 4;         // Safely behind the write pointer
            sel        = sel_t'(4'b0011 << (i % 3));
            data       = 32'hc0de_0000 + i;
            model[idx] = merge_lanes(model[idx], data, sel);
            bus_access(bus_addr_t'(idx), 1'b1, sel, data, rd);
            check_word($sformatf("%s wr%0d", name, i), model[idx], rd);
        end
    endtask

    task automatic wait_ready(input string name);
        int n;
        n = 0;
        do begin
            @(negedge gtp_clk);
            n++;
        end while (!cntrl_ready && n < 32);
        if (!cntrl_ready) begin
            other_errs++;
            $display("%s: cntrl_ready never rose after the last sample", name);
        end
    endtask

    task automatic run_capture(input string name, input int gap, input int nwr);
        word_t rd;
        limit += 4 * DEPTH + 20;
        @(posedge gtp_clk);
        cntrl_run <= 1'b1;          // Edge seen after the synchronizer
        repeat (3) @(posedge gtp_clk);
        cntrl_run <= 1'b0;
        @(negedge gtp_clk);
        check_flag({name, " armed"}, 1'b0, cntrl_ready);
        taken = 0;
        fork
            drive_samples(name, gap);
            bus_during_capture(name, nwr);
        join
        wait_ready(name);
        for (int i = 0; i < DEPTH; i++) begin  // Full readback
            bus_access(bus_addr_t'(i), 1'b0, '0, '0, rd);
            check_word($sformatf("%s[%0d]", name, i), model[i], rd);
        end
        @(negedge gtp_clk);
        check_flag({name, " held after readback"}, 1'b1, cntrl_ready);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int          fd;
        int          n;
        int          gap;
        int          nwr;
        string       line;
        string       cmd;
        string       name;
        string       tok;
        logic [31:0] a;
        logic [31:0] s;
        word_t       d;
        word_t       exp;
        word_t       rd;
        reset     = 1'b1;
        wb_adr    = '0;
        wb_dat_i  = '0;
        wb_sel    = '0;
        wb_we     = 1'b0;
        wb_stb    = 1'b0;
        wb_cyc    = 1'b0;
        gtp_dat   = '0;
        gtp_vld   = 1'b0;
        cntrl_run = 1'b0;
        for (int i = 0; i < DEPTH; i++) model[i] = '0;
        repeat (5) @(posedge gtp_clk);
        reset <= 1'b0;
        fd = $fopen("bench/capture_cases.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("Cannot open the cases file bench/capture_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%s %s", cmd, name);
                if (n < 2 || cmd[0] == "#") continue;   // Blank or comment
                case (cmd)
                    "capture": begin
                        void'($sscanf(line, "%s %s %d %d", cmd, name, gap, nwr));
                        run_capture(name, gap, nwr);
                    end
                    "write": begin
                        void'($sscanf(line, "%s %s %h %h %h", cmd, name, a, s, d));
                        exp = merge_lanes(model[a % DEPTH], d, sel_t'(s));
                        model[a % DEPTH] = exp;     // Upper bus addresses fold
                        bus_access(bus_addr_t'(a), 1'b1, sel_t'(s), d, rd);
                        check_word(name, exp, rd);
                    end
                    "read": begin
                        void'($sscanf(line, "%s %s %h %s", cmd, name, a, tok));
                        if (tok == "model") exp = model[a % DEPTH];
                        else void'($sscanf(tok, "%h", exp));
                        bus_access(bus_addr_t'(a), 1'b0, '0, '0, rd);
                        check_word(name, exp, rd);
                    end
                    default: begin
                        other_errs++;
                        $display("Unknown command %s in the cases file", cmd);
                    end
                endcase
            end
            $fclose(fd);
        end
        $display("Errors: word %0d, flag %0d, other %0d", word_errs, flag_errs, other_errs);
        if (word_errs + flag_errs + other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: bench/capture_cases.txt
# Columns: command, test name, then fields by command (numbers in hex unless noted)
#   capture <name> <gap_period, decimal, 0 for none> <bus writes during capture, decimal>
#   write   <name> <addr> <sel> <data>
#   read    <name> <addr> <expected data, or model for the captured word>

# Plain run, extra samples after the buffer is full must not show up
capture full_run      0 0
read    first_pair    000 model
read    last_pair     0ff model

# Runs with gtp_vld gaps, each re-arm overwrites from word 0
capture gap_run_3     3 0
read    gap_word0     000 model
capture gap_run_7     7 0

# Byte lane merge on captured words
write   lane_low      010 3 1234abcd
read    lane_low_rb   010 model
write   lane_high     011 c deadbeef
read    lane_high_rb  011 model

# Fixed pattern built from partial writes, also seen through the alias
write   pattern_clr   020 f 00000000
write   pattern_odd   020 5 ffffffff
read    pattern_rb    020 00ff00ff
read    pattern_alias 120 00ff00ff
write   pattern_b3    020 8 a5000000
read    pattern_b3_rb 020 a5ff00ff

# Bus writes landing on stored words while the stream runs
capture bus_during    0 6
capture bus_gaps      4 3
read    after_bus     000 model

// File: sources.f
hdl/capture_pkg.sv
hdl/capture_stream_if.sv
hdl/capture_mem_if.sv
hdl/sample_packer.sv
hdl/capture_ram.sv
hdl/wb_readout.sv
hdl/capture_top.sv
bench/capture_tb.sv

// File: Bender.yml
package:
  name: capture_buffer

sources:
  - files:
      - hdl/capture_pkg.sv
      - hdl/capture_stream_if.sv
      - hdl/capture_mem_if.sv
      - hdl/sample_packer.sv
      - hdl/capture_ram.sv
      - hdl/wb_readout.sv
      - hdl/capture_top.sv
  - target: test
    files:
      - bench/capture_tb.sv
